// ==== ahb_op_pkg.sv ====
// ----------------------------
// AHB-Lite field types
// Transfer and burst encodings
// Address and data payload structs
// Port index sizing
// ----------------------------

package ahb_op_pkg;

  // ----------------------------
  // Field types
  // ----------------------------
  typedef logic [31:0] haddr_t;            // HADDR
  typedef logic [31:0] hdata_t;            // HWDATA
  typedef logic [2:0]  huser_t;            // HAUSER and HWUSER
  typedef logic [2:0]  hsize_t;            // HSIZE
  typedef logic [3:0]  hprot_t;            // HPROT
  typedef logic [3:0]  hmaster_t;          // HMASTER

  // HTRANS encodings
  typedef enum logic [1:0] {
    IDLE   = 2'b00,                        // No transfer
    BUSY   = 2'b01,                        // Burst pause
    NONSEQ = 2'b10,                        // First beat or single
    SEQ    = 2'b11                         // Burst continuation
  } htrans_t;

  // HBURST encodings
  typedef enum logic [2:0] {
    SINGLE = 3'b000,
    INCR   = 3'b001,                       // Undefined length
    WRAP4  = 3'b010,
    INCR4  = 3'b011,
    WRAP8  = 3'b100,
    INCR8  = 3'b101,
    WRAP16 = 3'b110,
    INCR16 = 3'b111
  } hburst_t;

  // ----------------------------
  // Per-port payloads
  // ----------------------------
  typedef struct packed {
    logic     sel;                         // HSEL
    haddr_t   addr;
    huser_t   auser;
    htrans_t  trans;
    logic     write;
    hsize_t   size;
    hburst_t  burst;
    hprot_t   prot;
    hmaster_t master;
    logic     mastlock;
  } ahb_addr_ctrl_t;                       // Address phase

  typedef struct packed {
    hdata_t wdata;
    huser_t wuser;
  } ahb_wdata_t;                           // Data phase

  localparam int MAX_PORTS = 8;            // Bound on port count
  typedef logic [$clog2(MAX_PORTS)-1:0] port_idx_t;

endpackage

// ==== ahb_op_ctrl_if.sv ====
// ----------------------------
// Selected-port control bundle
// Address mux to arbiter and data phase
// ----------------------------

`timescale 1ns/100ps

interface ahb_op_ctrl_if;

  import ahb_op_pkg::*;

  logic    hsel;                           // HSEL of owner
  htrans_t trans;                          // HTRANS of owner
  hburst_t burst;                          // HBURST of owner
  logic    mastlock;                       // HMASTLOCK of owner
  logic    hreadymux;                      // Slave-side ready

  // Address mux side
  modport mux (
    output hsel, trans, burst, mastlock,
    input  hreadymux
  );

  // Arbitration sees everything
  modport arb (
    input hsel, trans, burst, mastlock, hreadymux
  );

  // Data phase needs select, owns ready
  modport dphase (
    input  hsel,
    output hreadymux
  );

endinterface

// ==== ahb_op_arb.sv ====
// ----------------------------
// Fixed-priority output arbiter
// Burst and lock hold
// Locked-sequence HSEL tracking
// ----------------------------

`timescale 1ns/100ps

module ahb_op_arb #(
  parameter int NUM_PORTS = 3              // Bus-switch inputs
) (
  input  logic                  HCLK,
  input  logic                  HRESETn,
  input  logic [NUM_PORTS-1:0]  i_hsel,       // Per-port HSEL
  input  logic [NUM_PORTS-1:0]  i_held_tran,  // Per-port HeldTran
  ahb_op_ctrl_if.arb            ctrl,         // Selected control
  output ahb_op_pkg::port_idx_t o_grant_port, // Address-phase owner
  output logic                  o_no_port     // Nobody owns the slave
);

  import ahb_op_pkg::*;

  // ----------------------------
  // Lock tracking
  // ----------------------------
  logic      hsel_lock;                    // Lock seen while selected
  logic      next_hsel_lock;
  logic      hlock_arb;                    // Lock as seen by arbitration
  logic      hold_burst;                   // Burst still in flight
  logic      hold_grant;
  port_idx_t next_grant;
  logic      next_no_port;

  // A locked master may deselect this slave mid-sequence and come back,
  // so the lock is remembered until HMASTLOCK itself drops
  always_comb
  begin
    next_hsel_lock = hsel_lock;            // Hold by default
    if (ctrl.hsel && ctrl.mastlock &&
        (ctrl.trans == NONSEQ || ctrl.trans == SEQ))
      next_hsel_lock = 1'b1;               // Locked transfer here
    else if (!ctrl.mastlock)
      next_hsel_lock = 1'b0;               // Sequence over
  end

  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      hsel_lock <= 1'b0;
    else if (ctrl.hreadymux)
      hsel_lock <= next_hsel_lock;         // Only on ready edges
  end

  assign hlock_arb = ctrl.mastlock & (hsel_lock | ctrl.hsel);

  // ----------------------------
  // Grant selection
  // ----------------------------
  assign hold_burst = ctrl.hsel &&
                      (ctrl.trans != IDLE) &&
                      (ctrl.burst != SINGLE); // Mid-burst
  assign hold_grant = hlock_arb | hold_burst;

  always_comb
  begin
    next_grant   = o_grant_port;           // Keep owner
    next_no_port = o_no_port;
    if (!hold_grant)
    begin
      next_no_port = 1'b1;                 // Assume no requester
      // Walk down so the lowest index wins
      for (int i = NUM_PORTS - 1; i >= 0; i--)
      begin
        if (i_held_tran[i] && i_hsel[i])   // Qualified request
        begin
          next_grant   = port_idx_t'(i);
          next_no_port = 1'b0;
        end
      end
    end
  end

  // Grant moves only when the slave side is ready
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
    begin
      o_grant_port <= '0;
      o_no_port    <= 1'b1;                // Idle after reset
    end
    else if (ctrl.hreadymux)
    begin
      o_grant_port <= next_grant;
      o_no_port    <= next_no_port;
    end
  end

endmodule

// ==== ahb_op_addr_mux.sv ====
// ----------------------------
// Address-phase payload mux
// Active-port decode
// ----------------------------

`timescale 1ns/100ps

module ahb_op_addr_mux #(
  parameter int NUM_PORTS = 3              // Bus-switch inputs
) (
  input  ahb_op_pkg::ahb_addr_ctrl_t [NUM_PORTS-1:0] i_addr_ctrl,  // Per port
  input  ahb_op_pkg::port_idx_t                      i_grant_port, // Owner
  input  logic                                       i_no_port,    // No owner
  ahb_op_ctrl_if.mux                                 ctrl,         // To arb
  output ahb_op_pkg::ahb_addr_ctrl_t                 o_addr_ctrl,  // To slave
  output logic [NUM_PORTS-1:0]                       o_active      // One-hot
);

  import ahb_op_pkg::*;

  ahb_addr_ctrl_t sel_addr_ctrl;           // Chosen payload
  logic [NUM_PORTS-1:0] active;

  // ----------------------------
  // Select and decode
  // ----------------------------
  // Zero payload when idle keeps HSEL and HTRANS quiet on the slave
  always_comb
  begin
    sel_addr_ctrl = '0;                    // Nothing selected
    active        = '0;
    if (!i_no_port)
    begin
      for (int i = 0; i < NUM_PORTS; i++)
      begin
        if (i_grant_port == port_idx_t'(i))
        begin
          sel_addr_ctrl = i_addr_ctrl[i];  // Owner payload
          active[i]     = 1'b1;            // Owner flag
        end
      end
    end
  end

  assign o_addr_ctrl = sel_addr_ctrl;
  assign o_active    = active;

  // ----------------------------
  // Control back to arbitration
  // ----------------------------
  assign ctrl.hsel     = sel_addr_ctrl.sel;
  assign ctrl.trans    = sel_addr_ctrl.trans;
  assign ctrl.burst    = sel_addr_ctrl.burst;
  assign ctrl.mastlock = sel_addr_ctrl.mastlock;

endmodule

// ==== ahb_op_data_phase.sv ====
// ----------------------------
// Data-phase port register
// Write data and user mux
// HREADYMUX generation
// ----------------------------

`timescale 1ns/100ps

module ahb_op_data_phase #(
  parameter int NUM_PORTS = 3              // Bus-switch inputs
) (
  input  logic                                   HCLK,
  input  logic                                   HRESETn,
  input  ahb_op_pkg::ahb_wdata_t [NUM_PORTS-1:0] i_wdata,      // Per port
  input  ahb_op_pkg::port_idx_t                  i_grant_port, // Addr owner
  input  logic                                   i_hreadyout,  // From slave
  ahb_op_ctrl_if.dphase                          ctrl,
  output ahb_op_pkg::ahb_wdata_t                 o_wdata       // To slave
);

  import ahb_op_pkg::*;

  port_idx_t  data_port;                   // Data-phase owner
  logic       slave_sel;                   // Slave in data phase
  logic       hready_mux;
  ahb_wdata_t sel_wdata;

  // ----------------------------
  // Phase registers
  // ----------------------------
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
    begin
      data_port <= '0;
      slave_sel <= 1'b0;                   // No transfer pending
    end
    else if (hready_mux)
    begin
      data_port <= i_grant_port;           // Address phase ends
      slave_sel <= ctrl.hsel;
    end
  end

  // Slave only stalls the bus when it owns the data phase
  assign hready_mux     = slave_sel ? i_hreadyout : 1'b1;
  assign ctrl.hreadymux = hready_mux;

  // Write payload follows the data-phase owner
  always_comb
  begin
    sel_wdata = '0;
    for (int i = 0; i < NUM_PORTS; i++)
    begin
      if (data_port == port_idx_t'(i))
        sel_wdata = i_wdata[i];            // Owner data
    end
  end

  assign o_wdata = sel_wdata;

endmodule

// ==== ahb_op_stage.sv ====
// ----------------------------
// AHB-Lite shared-slave output stage
// Arbiter, address mux, data phase
// ----------------------------

`timescale 1ns/100ps

module ahb_op_stage #(
  parameter int NUM_PORTS = 3              // Bus-switch inputs
) (
  input  logic                                 HCLK,
  input  logic                                 HRESETn,
  // Bus-switch inputs
  input  logic                [NUM_PORTS-1:0]  i_hsel,
  input  ahb_op_pkg::htrans_t [NUM_PORTS-1:0]  i_htrans,
  input  ahb_op_pkg::hburst_t [NUM_PORTS-1:0]  i_hburst,
  input  logic                [NUM_PORTS-1:0]  i_hmastlock,
  input  logic                [NUM_PORTS-1:0]  i_hwrite,
  input  ahb_op_pkg::hsize_t  [NUM_PORTS-1:0]  i_hsize,
  input  ahb_op_pkg::hprot_t  [NUM_PORTS-1:0]  i_hprot,
  input  ahb_op_pkg::hmaster_t [NUM_PORTS-1:0] i_hmaster,
  input  ahb_op_pkg::haddr_t  [NUM_PORTS-1:0]  i_haddr,
  input  ahb_op_pkg::huser_t  [NUM_PORTS-1:0]  i_hauser,
  input  ahb_op_pkg::hdata_t  [NUM_PORTS-1:0]  i_hwdata,
  input  ahb_op_pkg::huser_t  [NUM_PORTS-1:0]  i_hwuser,
  input  logic                [NUM_PORTS-1:0]  i_held_tran,
  input  logic                                 i_hreadyout, // Slave HREADYOUT
  // Port status
  output logic                [NUM_PORTS-1:0]  o_active,
  // Shared slave
  output logic                                 o_hsel,
  output ahb_op_pkg::haddr_t                   o_haddr,
  output ahb_op_pkg::huser_t                   o_hauser,
  output ahb_op_pkg::htrans_t                  o_htrans,
  output logic                                 o_hwrite,
  output ahb_op_pkg::hsize_t                   o_hsize,
  output ahb_op_pkg::hburst_t                  o_hburst,
  output ahb_op_pkg::hprot_t                   o_hprot,
  output ahb_op_pkg::hmaster_t                 o_hmaster,
  output logic                                 o_hmastlock,
  output logic                                 o_hreadymux, // Bus ready
  output ahb_op_pkg::hdata_t                   o_hwdata,
  output ahb_op_pkg::huser_t                   o_hwuser
);

  import ahb_op_pkg::*;

  ahb_addr_ctrl_t [NUM_PORTS-1:0] addr_ctrl;   // Packed address payloads
  ahb_wdata_t     [NUM_PORTS-1:0] wdata;       // Packed write payloads
  ahb_addr_ctrl_t                 addr_ctrl_out;
  ahb_wdata_t                     wdata_out;
  port_idx_t                      grant_port;  // Registered owner
  logic                           no_port;

  ahb_op_ctrl_if u_ctrl_if ();                 // Selected control bundle

  // ----------------------------
  // Pack per-port inputs
  // ----------------------------
  always_comb
  begin
    for (int i = 0; i < NUM_PORTS; i++)
    begin
      addr_ctrl[i].sel      = i_hsel[i];
      addr_ctrl[i].addr     = i_haddr[i];
      addr_ctrl[i].auser    = i_hauser[i];
      addr_ctrl[i].trans    = i_htrans[i];
      addr_ctrl[i].write    = i_hwrite[i];
      addr_ctrl[i].size     = i_hsize[i];
      addr_ctrl[i].burst    = i_hburst[i];
      addr_ctrl[i].prot     = i_hprot[i];
      addr_ctrl[i].master   = i_hmaster[i];
      addr_ctrl[i].mastlock = i_hmastlock[i];
      wdata[i].wdata        = i_hwdata[i];
      wdata[i].wuser        = i_hwuser[i];
    end
  end

  // ----------------------------
  // Sub-blocks
  // ----------------------------
  ahb_op_arb #(
    .NUM_PORTS (NUM_PORTS)
  ) u_arb (
    .HCLK         (HCLK),
    .HRESETn      (HRESETn),
    .i_hsel       (i_hsel),
    .i_held_tran  (i_held_tran),
    .ctrl         (u_ctrl_if.arb),
    .o_grant_port (grant_port),
    .o_no_port    (no_port)
  );

  ahb_op_addr_mux #(
    .NUM_PORTS (NUM_PORTS)
  ) u_addr_mux (
    .i_addr_ctrl  (addr_ctrl),
    .i_grant_port (grant_port),
    .i_no_port    (no_port),
    .ctrl         (u_ctrl_if.mux),
    .o_addr_ctrl  (addr_ctrl_out),
    .o_active     (o_active)
  );

  ahb_op_data_phase #(
    .NUM_PORTS (NUM_PORTS)
  ) u_data_phase (
    .HCLK         (HCLK),
    .HRESETn      (HRESETn),
    .i_wdata      (wdata),
    .i_grant_port (grant_port),
    .i_hreadyout  (i_hreadyout),
    .ctrl         (u_ctrl_if.dphase),
    .o_wdata      (wdata_out)
  );

  // ----------------------------
  // Unpack slave side
  // ----------------------------
  assign o_hsel      = addr_ctrl_out.sel;
  assign o_haddr     = addr_ctrl_out.addr;
  assign o_hauser    = addr_ctrl_out.auser;
  assign o_htrans    = addr_ctrl_out.trans;
  assign o_hwrite    = addr_ctrl_out.write;
  assign o_hsize     = addr_ctrl_out.size;
  assign o_hburst    = addr_ctrl_out.burst;
  assign o_hprot     = addr_ctrl_out.prot;
  assign o_hmaster   = addr_ctrl_out.master;
  assign o_hmastlock = addr_ctrl_out.mastlock;
  assign o_hreadymux = u_ctrl_if.hreadymux;   // Shared with the arbiter
  assign o_hwdata    = wdata_out.wdata;
  assign o_hwuser    = wdata_out.wuser;

endmodule

// ==== tb_ahb_op_stage.sv ====
// ----------------------------
// Testbench for the output stage
// Reference model and compare process
// Directed and random stimulus
// Watchdog
// ----------------------------

`timescale 1ns/100ps

module tb_ahb_op_stage;

  import ahb_op_pkg::*;

  localparam int NUM_PORTS    = 3;
  localparam int CLK_PERIOD   = 100;         // ns
  localparam int DRIVE_DELAY  = 10;          // After rising edge
  localparam int RAND_CYCLES  = 30;          // Per random test
  localparam int TOTAL_CYCLES = 2 + 4 + 3 * RAND_CYCLES + 20 + 20;

  logic HCLK;
  logic HRESETn;
  // DUT inputs, one entry per port
  logic     [NUM_PORTS-1:0] hsel;
  htrans_t  [NUM_PORTS-1:0] htrans;
  hburst_t  [NUM_PORTS-1:0] hburst;
  logic     [NUM_PORTS-1:0] hmastlock;
  logic     [NUM_PORTS-1:0] hwrite;
  hsize_t   [NUM_PORTS-1:0] hsize;
  hprot_t   [NUM_PORTS-1:0] hprot;
  hmaster_t [NUM_PORTS-1:0] hmaster;
  haddr_t   [NUM_PORTS-1:0] haddr;
  huser_t   [NUM_PORTS-1:0] hauser;
  hdata_t   [NUM_PORTS-1:0] hwdata;
  huser_t   [NUM_PORTS-1:0] hwuser;
  logic     [NUM_PORTS-1:0] held_tran;
  logic                     hreadyout;
  // DUT outputs
  logic     [NUM_PORTS-1:0] o_active;
  logic     o_hsel;
  haddr_t   o_haddr;
  huser_t   o_hauser;
  htrans_t  o_htrans;
  logic     o_hwrite;
  hsize_t   o_hsize;
  hburst_t  o_hburst;
  hprot_t   o_hprot;
  hmaster_t o_hmaster;
  logic     o_hmastlock;
  logic     o_hreadymux;
  hdata_t   o_hwdata;
  huser_t   o_hwuser;

  // Shadow state and its next value
  int   m_grant, n_grant;
  logic m_no_port, n_no_port;
  logic m_lock, n_lock;                      // Shadow of hsel_lock
  int   m_dport, n_dport;
  logic m_ssel, n_ssel;
  logic m_edge_ready;                        // Bus was ready at last edge
  logic exp_owned;
  logic exp_ready;
  logic [NUM_PORTS-1:0] exp_active;

  int errors;
  int tests;
  int failed_tests;
  int test_err_base;

  ahb_op_stage #(
    .NUM_PORTS (NUM_PORTS)
  ) i_ahb_op_stage (
    .HCLK (HCLK), .HRESETn (HRESETn),
    .i_hsel (hsel), .i_htrans (htrans), .i_hburst (hburst),
    .i_hmastlock (hmastlock), .i_hwrite (hwrite), .i_hsize (hsize),
    .i_hprot (hprot), .i_hmaster (hmaster), .i_haddr (haddr),
    .i_hauser (hauser), .i_hwdata (hwdata), .i_hwuser (hwuser),
    .i_held_tran (held_tran), .i_hreadyout (hreadyout),
    .o_active (o_active), .o_hsel (o_hsel), .o_haddr (o_haddr),
    .o_hauser (o_hauser), .o_htrans (o_htrans), .o_hwrite (o_hwrite),
    .o_hsize (o_hsize), .o_hburst (o_hburst), .o_hprot (o_hprot),
    .o_hmaster (o_hmaster), .o_hmastlock (o_hmastlock),
    .o_hreadymux (o_hreadymux), .o_hwdata (o_hwdata), .o_hwuser (o_hwuser)
  );

  initial HCLK = 1'b0;
  always #(CLK_PERIOD / 2) HCLK = ~HCLK;

  // ----------------------------
  // Reference model
  // ----------------------------
  function automatic void ref_model();
    logic    s_hsel;
    htrans_t s_trans;
    hburst_t s_burst;
    logic    s_lock;
    logic    hold;
    logic    found;
    exp_owned  = !m_no_port;
    exp_active = exp_owned ? (NUM_PORTS'(1) << m_grant) : '0;
    s_hsel     = exp_owned & hsel[m_grant];  // Owner's control only
    s_trans    = exp_owned ? htrans[m_grant] : IDLE;
    s_burst    = exp_owned ? hburst[m_grant] : SINGLE;
    s_lock     = exp_owned & hmastlock[m_grant];
    exp_ready  = m_ssel ? hreadyout : 1'b1;  // Stall only in own data phase
    hold = (s_lock && (m_lock || s_hsel)) ||
           (s_hsel && s_trans != IDLE && s_burst != SINGLE);
    n_grant   = m_grant;
    n_no_port = m_no_port;
    n_lock    = m_lock;
    n_dport   = m_dport;
    n_ssel    = m_ssel;
    if (exp_ready)
    begin
      if (s_hsel && s_lock && (s_trans == NONSEQ || s_trans == SEQ))
        n_lock = 1'b1;
      else if (!s_lock)
        n_lock = 1'b0;
      if (!hold)
      begin
        found = 1'b0;
        for (int i = 0; i < NUM_PORTS; i++)
        begin
          if (!found && held_tran[i] && hsel[i])  // First requester wins
          begin
            n_grant = i;
            found   = 1'b1;
          end
        end
        n_no_port = !found;
      end
      n_dport = m_grant;                     // Address phase moves to data
      n_ssel  = s_hsel;
    end
  endfunction

  always @(posedge HCLK)
  begin
    if (!HRESETn)
    begin
      m_grant      <= 0;
      m_no_port    <= 1'b1;
      m_lock       <= 1'b0;
      m_dport      <= 0;
      m_ssel       <= 1'b0;
      m_edge_ready <= 1'b1;
    end
    else
    begin
      ref_model();
      m_grant      <= n_grant;
      m_no_port    <= n_no_port;
      m_lock       <= n_lock;
      m_dport      <= n_dport;
      m_ssel       <= n_ssel;
      m_edge_ready <= exp_ready;
    end
  end

  // ----------------------------
  // Checker
  // ----------------------------
  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp)
    begin
      $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  // All outputs against the model, mid-cycle
  always @(negedge HCLK)
  begin
    if (HRESETn)
    begin
      ref_model();
      check_value("o_active", o_active, exp_active);
      check_value("o_hsel", o_hsel, exp_owned & hsel[m_grant]);
      check_value("o_haddr", o_haddr, exp_owned ? haddr[m_grant] : '0);
      check_value("o_hauser", o_hauser, exp_owned ? hauser[m_grant] : '0);
      check_value("o_htrans", o_htrans, exp_owned ? htrans[m_grant] : IDLE);
      check_value("o_hwrite", o_hwrite, exp_owned & hwrite[m_grant]);
      check_value("o_hsize", o_hsize, exp_owned ? hsize[m_grant] : '0);
      check_value("o_hburst", o_hburst, exp_owned ? hburst[m_grant] : SINGLE);
      check_value("o_hprot", o_hprot, exp_owned ? hprot[m_grant] : '0);
      check_value("o_hmaster", o_hmaster, exp_owned ? hmaster[m_grant] : '0);
      check_value("o_hmastlock", o_hmastlock, exp_owned & hmastlock[m_grant]);
      check_value("o_hreadymux", o_hreadymux, exp_ready);
      check_value("o_hwdata", o_hwdata, hwdata[m_dport]);  // Data-phase owner
      check_value("o_hwuser", o_hwuser, hwuser[m_dport]);
    end
  end

  // ----------------------------
  // Stimulus helpers
  // ----------------------------
  task automatic next_cycle();
    @(posedge HCLK);
    #DRIVE_DELAY;
  endtask

  task automatic drive_idle();
    for (int i = 0; i < NUM_PORTS; i++)
    begin
      htrans[i] = IDLE;
      hburst[i] = SINGLE;
    end
    hsel      = '0;
    hmastlock = '0;
    hwrite    = '0;
    hsize     = '0;
    hprot     = '0;
    hmaster   = '0;
    haddr     = '0;
    hauser    = '0;
    hwdata    = '0;
    hwuser    = '0;
    held_tran = '1;                          // Requests pass by default
    hreadyout = 1'b1;
  endtask

  // Until the port owns the address phase
  task automatic wait_active(input int port, input int limit);
    int n;
    n = 0;
    while (o_active !== (NUM_PORTS'(1) << port) && n < limit)
    begin
      next_cycle();
      n++;
    end
    if (o_active !== (NUM_PORTS'(1) << port))
    begin
      $display("Port %0d was not granted within %0d cycles", port, limit);
      errors++;
    end
  endtask

  task automatic random_singles(input int n, input bit waits);
    for (int c = 0; c < n; c++)
    begin
      if (m_edge_ready)                      // Masters hold during waits
      begin
        for (int i = 0; i < NUM_PORTS; i++)
        begin
          hsel[i]      = 1'($urandom);
          htrans[i]    = ($urandom % 4 != 0) ? NONSEQ : IDLE;
          hburst[i]    = SINGLE;
          held_tran[i] = ($urandom % 4) != 0;
          hwrite[i]    = 1'($urandom);
          hsize[i]     = hsize_t'($urandom % 3);
          hprot[i]     = hprot_t'($urandom);
          hmaster[i]   = hmaster_t'($urandom);
          haddr[i]     = $urandom;
          hauser[i]    = huser_t'($urandom);
          hwdata[i]    = $urandom;
          hwuser[i]    = huser_t'($urandom);
        end
      end
      hreadyout = waits ? ($urandom % 3 != 0) : 1'b1;
      next_cycle();
    end
    drive_idle();
  endtask

  task automatic burst_hold();
    drive_idle();
    hsel[2]   = 1'b1;                        // Low-priority INCR4
    htrans[2] = NONSEQ;
    hburst[2] = INCR4;
    haddr[2]  = 32'h2000_0040;
    wait_active(2, 5);
    hsel[0]   = 1'b1;                        // Port 0 asks mid-burst
    htrans[0] = NONSEQ;
    haddr[0]  = 32'h1000_0000;
    for (int b = 1; b < 4; b++)
    begin
      next_cycle();
      check_value("burst owner", o_active, 3'b100);
      htrans[2] = SEQ;
      haddr[2]  = haddr[2] + 32'd4;
    end
    next_cycle();
    check_value("burst owner", o_active, 3'b100);
    htrans[2] = IDLE;                        // Burst over
    hsel[2]   = 1'b0;
    wait_active(0, 3);
    next_cycle();
    drive_idle();
    repeat (2) next_cycle();
  endtask

  task automatic lock_hold();
    drive_idle();
    hsel[1]      = 1'b1;
    htrans[1]    = NONSEQ;
    hmastlock[1] = 1'b1;
    haddr[1]     = 32'h3000_0000;
    wait_active(1, 5);
    hsel[0]   = 1'b1;                        // Competing request
    htrans[0] = NONSEQ;
    next_cycle();
    hsel[1]   = 1'b0;                        // Leaves slave, still locked
    htrans[1] = IDLE;
    repeat (2)
    begin
      next_cycle();
      check_value("lock owner", o_active, 3'b010);
    end
    hsel[1]   = 1'b1;                        // Back for the last beat
    htrans[1] = NONSEQ;
    next_cycle();
    check_value("lock owner", o_active, 3'b010);
    hsel[1]      = 1'b0;
    htrans[1]    = IDLE;
    hmastlock[1] = 1'b0;                     // Sequence ends
    wait_active(0, 3);
    next_cycle();
    drive_idle();
    repeat (2) next_cycle();
  endtask

  task automatic end_test(input string name);
    tests++;
    if (errors > test_err_base)
    begin
      failed_tests++;
      $display("[%s] failed with %0d errors", name, errors - test_err_base);
    end
    else
      $display("[%s] passed", name);
    test_err_base = errors;
  endtask

  // ----------------------------
  // Test sequence
  // ----------------------------
  initial
  begin
    void'($urandom(57));
    errors        = 0;
    tests         = 0;
    failed_tests  = 0;
    test_err_base = 0;
    drive_idle();
    HRESETn = 1'b0;
    repeat (2) @(posedge HCLK);
    #DRIVE_DELAY;
    HRESETn = 1'b1;
    repeat (4) next_cycle();
    end_test("idle after reset");
    random_singles(RAND_CYCLES, 1'b0);
    end_test("fixed priority");
    random_singles(RAND_CYCLES, 1'b0);
    end_test("data phase");
    random_singles(RAND_CYCLES, 1'b1);
    end_test("wait states");
    burst_hold();
    end_test("burst hold");
    lock_hold();
    end_test("lock hold");
    $display("Tests: %0d, failed tests: %0d, errors: %0d", tests, failed_tests, errors);
    if (errors == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

  // Twice the expected run length
  initial
  begin
    #(TOTAL_CYCLES * CLK_PERIOD * 2);
    $display("Watchdog expired before the tests completed");
    $display("TEST FAILED");
    $finish;
  end

endmodule

// ==== filelist.f ====
ahb_op_pkg.sv
ahb_op_ctrl_if.sv
ahb_op_arb.sv
ahb_op_addr_mux.sv
ahb_op_data_phase.sv
ahb_op_stage.sv
tb_ahb_op_stage.sv

// ==== Bender.yml ====
package:
  name: ahb_op_stage

sources:
  - ahb_op_pkg.sv
  - ahb_op_ctrl_if.sv
  - ahb_op_arb.sv
  - ahb_op_addr_mux.sv
  - ahb_op_data_phase.sv
  - ahb_op_stage.sv
  - target: test
    files:
      - tb_ahb_op_stage.sv
